//--- logic/dma_defines.svh
////////////////////////////////////////
// DMA width and depth macros
////////////////////////////////////////

`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

`define DMA_DATA_W      32   // Bus word
`define DMA_MADDR_W     8    // SRAM word address
`define DMA_MEM_DEPTH   256  // SRAM words
`define DMA_SLOTS       4    // Request table entries
`define DMA_SLOT_W      2    // Slot index
`define DMA_CFG_ADDR_W  6    // Config byte address

`endif

//--- logic/dma_pkg.sv
////////////////////////////////////////
// DMA shared types
////////////////////////////////////////

`include "dma_defines.svh"

`default_nettype none

package dma_pkg;

  typedef logic [`DMA_DATA_W-1:0]  word_t;       // One data word
  typedef logic [`DMA_MADDR_W-1:0] maddr_t;      // SRAM word address
  typedef logic [`DMA_MADDR_W-1:0] len_t;        // Copy length, 0 = nothing
  typedef logic [`DMA_SLOT_W-1:0]  slot_t;       // Table slot index
  typedef logic [`DMA_SLOTS-1:0]   slot_mask_t;  // One bit per slot

  // Copy engine FSM
  typedef enum logic [2:0] {IDLE, LOAD, READ, WRITE, FINISH} copy_state_e;

  // Who currently drives the SRAM bus
  typedef enum logic {OWN_ACCESS, OWN_COPY} bus_owner_e;

endpackage

`default_nettype wire

//--- logic/dma_ifs.sv
////////////////////////////////////////
// DMA internal links
////////////////////////////////////////

`default_nettype none

// Simplified AHB-Lite style bus, one outstanding transfer
interface dma_bus_if;
  import dma_pkg::*;

  logic   hsel;       // Transfer request
  maddr_t haddr;
  logic   hwrite;
  word_t  hwdata;
  word_t  hrdata;     // Valid with hready on reads
  logic   hready;     // One-cycle completion pulse
  logic   hmastlock;  // Ownership request, held over a sequence

  modport initiator (output hsel, haddr, hwrite, hwdata, hmastlock,
                     input  hrdata, hready);
  modport memory    (input  hsel, haddr, hwrite, hwdata, hmastlock,
                     output hrdata, hready);
endinterface

// Request table to copy engine
interface dma_ctrl_if;
  import dma_pkg::*;

  slot_mask_t valid;     // Pending slots
  slot_t      read_pos;  // Slot shown on src/dst/len
  maddr_t     src;
  maddr_t     dst;
  len_t       len;
  slot_t      done_pos;
  logic       done_en;   // Single-cycle completion strobe

  modport tbl    (output valid, src, dst, len, input  read_pos, done_pos, done_en);
  modport engine (input  valid, src, dst, len, output read_pos, done_pos, done_en);
endinterface

`default_nettype wire

//--- logic/dma_request_table.sv
////////////////////////////////////////
// DMA request table
////////////////////////////////////////

`include "dma_defines.svh"

`default_nettype none

module dma_request_table (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cfg_hsel,
  input  logic                       cfg_hwrite,
  input  logic [`DMA_CFG_ADDR_W-1:0] cfg_haddr,
  input  dma_pkg::word_t             cfg_hwdata,
  output dma_pkg::word_t             cfg_hrdata,
  dma_ctrl_if.tbl                    ctrl,
  output dma_pkg::slot_mask_t        irq
);
  import dma_pkg::*;

  ////////////////////////////////////////
  // Slot storage
  ////////////////////////////////////////

  maddr_t     src_r [`DMA_SLOTS];
  maddr_t     dst_r [`DMA_SLOTS];
  len_t       len_r [`DMA_SLOTS];
  slot_mask_t valid_r;
  slot_mask_t done_r;

  slot_t       sel_slot;  // Addressed slot
  logic [1:0]  sel_word;  // 0 src, 1 dst, 2 len, 3 ctrl
  logic        wr_en;

  assign sel_slot = cfg_haddr[5:4];
  assign sel_word = cfg_haddr[3:2];
  assign wr_en    = cfg_hsel && cfg_hwrite;

  // Descriptor words, locked while the slot is pending
  always_ff @(posedge clk) begin
    if (wr_en && !valid_r[sel_slot]) begin
      case (sel_word)
        2'd0:    src_r[sel_slot] <= maddr_t'(cfg_hwdata);
        2'd1:    dst_r[sel_slot] <= maddr_t'(cfg_hwdata);
        2'd2:    len_r[sel_slot] <= len_t'(cfg_hwdata);
        default: ;  // Ctrl handled below
      endcase
    end
  end

  // Valid / done bookkeeping
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r <= '0;
      done_r  <= '0;
    end else begin
      if (ctrl.done_en) begin
        valid_r[ctrl.done_pos] <= 1'b0;  // Engine finished
        done_r[ctrl.done_pos]  <= 1'b1;
      end
      if (wr_en && sel_word == 2'd3) begin
        if (cfg_hwdata[0]) valid_r[sel_slot] <= 1'b1;  // Queue slot
        if (cfg_hwdata[1]) done_r[sel_slot]  <= 1'b0;  // Ack irq
      end
    end
  end

  // Registered read data, one cycle after the access
  always_ff @(posedge clk) begin
    if (cfg_hsel && !cfg_hwrite) begin
      case (sel_word)
        2'd0:    cfg_hrdata <= word_t'(src_r[sel_slot]);
        2'd1:    cfg_hrdata <= word_t'(dst_r[sel_slot]);
        2'd2:    cfg_hrdata <= word_t'(len_r[sel_slot]);
        default: cfg_hrdata <= word_t'({done_r[sel_slot], valid_r[sel_slot]});
      endcase
    end
  end

  // Engine view of the selected slot
  assign ctrl.valid = valid_r;
  assign ctrl.src   = src_r[ctrl.read_pos];
  assign ctrl.dst   = dst_r[ctrl.read_pos];
  assign ctrl.len   = len_r[ctrl.read_pos];

  assign irq = done_r;  // One line per slot

endmodule

`default_nettype wire

//--- logic/dma_copy_engine.sv
////////////////////////////////////////
// DMA copy engine
////////////////////////////////////////

`include "dma_defines.svh"

`default_nettype none

module dma_copy_engine (
  input  logic         clk,
  input  logic         rst,
  dma_ctrl_if.engine   ctrl,
  dma_bus_if.initiator bus
);
  import dma_pkg::*;

  copy_state_e state;
  slot_t       slot;       // Slot in progress
  slot_t       first_slot; // Lowest pending slot
  maddr_t      src_q;
  maddr_t      dst_q;
  len_t        len_q;
  len_t        idx;        // Word counter
  len_t        idx_nxt;

  // Priority pick, lowest index wins
  always_comb begin
    first_slot = '0;
    for (int i = `DMA_SLOTS - 1; i >= 0; i--) begin
      if (ctrl.valid[i]) first_slot = slot_t'(i);
    end
  end

  assign idx_nxt = idx + 1'b1;

  ////////////////////////////////////////
  // Copy FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= IDLE;
      slot          <= '0;
      bus.hsel      <= 1'b0;
      bus.hmastlock <= 1'b0;
    end else begin
      case (state)
        IDLE: if (|ctrl.valid) begin
          slot  <= first_slot;
          state <= LOAD;
        end
        LOAD: begin  // Table shows slot now
          src_q <= ctrl.src;
          dst_q <= ctrl.dst;
          len_q <= ctrl.len;
          idx   <= '0;
          state <= (ctrl.len == '0) ? FINISH : READ;
        end
        READ: if (!bus.hmastlock) begin
          bus.hmastlock <= 1'b1;  // Lock for the read/write pair
          bus.hsel      <= 1'b1;
          bus.haddr     <= src_q + maddr_t'(idx);
          bus.hwrite    <= 1'b0;
        end else if (bus.hready) begin
          bus.hwdata <= bus.hrdata;  // Forward read word
          bus.hsel   <= 1'b0;
          state      <= WRITE;
        end
        WRITE: if (!bus.hsel) begin
          bus.hsel   <= 1'b1;
          bus.haddr  <= dst_q + maddr_t'(idx);
          bus.hwrite <= 1'b1;
        end else if (bus.hready) begin
          bus.hsel      <= 1'b0;
          bus.hmastlock <= 1'b0;  // Free bus between words
          idx           <= idx_nxt;
          state         <= (idx_nxt == len_q) ? FINISH : READ;
        end
        FINISH: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign ctrl.read_pos = slot;
  assign ctrl.done_pos = slot;
  assign ctrl.done_en  = (state == FINISH);  // One cycle

endmodule

`default_nettype wire

//--- logic/dma_access_port.sv
////////////////////////////////////////
// DMA external access port
////////////////////////////////////////

`default_nettype none

module dma_access_port (
  input  logic            clk,
  input  logic            rst,
  input  logic            mem_req_valid,
  output logic            mem_req_ready,
  input  logic            mem_req_write,
  input  dma_pkg::maddr_t mem_req_addr,
  input  dma_pkg::word_t  mem_req_wdata,
  output logic            mem_rsp_valid,
  output dma_pkg::word_t  mem_rsp_rdata,
  input  logic            mem_rsp_ready,
  dma_bus_if.initiator    bus
);
  import dma_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req_ready <= 1'b0;
      mem_rsp_valid <= 1'b0;
      bus.hsel      <= 1'b0;
      bus.hmastlock <= 1'b0;
    end else if (mem_req_valid && mem_req_ready) begin
      mem_req_ready <= 1'b0;           // One request at a time
      bus.hsel      <= 1'b1;
      bus.hmastlock <= 1'b1;           // Single locked transfer
      bus.haddr     <= mem_req_addr;
      bus.hwrite    <= mem_req_write;
      bus.hwdata    <= mem_req_wdata;
    end else if (bus.hsel && bus.hready) begin
      bus.hsel      <= 1'b0;
      bus.hmastlock <= 1'b0;
      mem_rsp_valid <= 1'b1;
      mem_rsp_rdata <= bus.hwrite ? '0 : bus.hrdata;  // Writes answer 0
    end else if (mem_rsp_valid && mem_rsp_ready) begin
      mem_rsp_valid <= 1'b0;
      mem_req_ready <= 1'b1;
    end else if (!mem_rsp_valid && !bus.hmastlock) begin
      mem_req_ready <= 1'b1;           // Idle, also first cycle out of reset
    end
  end

endmodule

`default_nettype wire

//--- logic/dma_bus_arbiter.sv
////////////////////////////////////////
// DMA bus arbiter
////////////////////////////////////////

`default_nettype none

module dma_bus_arbiter (
  input  logic         clk,
  input  logic         rst,
  dma_bus_if.memory    acc,  // Access port side
  dma_bus_if.memory    cpy,  // Copy engine side
  dma_bus_if.initiator mem   // Toward SRAM
);
  import dma_pkg::*;

  bus_owner_e owner;
  bus_owner_e owner_nxt;
  logic       owner_locked;

  assign owner_locked = (owner == OWN_ACCESS) ? acc.hmastlock : cpy.hmastlock;

  // Re-arbitrate only once the owner lets go; access port wins ties
  always_comb begin
    owner_nxt = owner;
    if (!owner_locked) begin
      if (acc.hmastlock)      owner_nxt = OWN_ACCESS;
      else if (cpy.hmastlock) owner_nxt = OWN_COPY;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) owner <= OWN_ACCESS;
    else     owner <= owner_nxt;  // Grant next cycle
  end

  ////////////////////////////////////////
  // Bus routing
  ////////////////////////////////////////

  always_comb begin
    if (owner == OWN_ACCESS) begin
      mem.hsel      = acc.hsel;
      mem.haddr     = acc.haddr;
      mem.hwrite    = acc.hwrite;
      mem.hwdata    = acc.hwdata;
      mem.hmastlock = acc.hmastlock;
    end else begin
      mem.hsel      = cpy.hsel;
      mem.haddr     = cpy.haddr;
      mem.hwrite    = cpy.hwrite;
      mem.hwdata    = cpy.hwdata;
      mem.hmastlock = cpy.hmastlock;
    end
  end

  // Responses go to the owner only
  assign acc.hready = (owner == OWN_ACCESS) && mem.hready;
  assign cpy.hready = (owner == OWN_COPY) && mem.hready;
  assign acc.hrdata = (owner == OWN_ACCESS) ? mem.hrdata : '0;
  assign cpy.hrdata = (owner == OWN_COPY) ? mem.hrdata : '0;

endmodule

`default_nettype wire

//--- logic/dma_sram.sv
////////////////////////////////////////
// DMA word SRAM
////////////////////////////////////////

`include "dma_defines.svh"

`default_nettype none

module dma_sram (
  input  logic      clk,
  input  logic      rst,
  dma_bus_if.memory bus
);
  import dma_pkg::*;

  word_t mem [`DMA_MEM_DEPTH];
  logic  access;

  // New locked access, not the one being answered
  assign access = bus.hsel && bus.hmastlock && !bus.hready;

  always_ff @(posedge clk) begin
    if (access && bus.hwrite)  mem[bus.haddr] <= bus.hwdata;
    if (access && !bus.hwrite) bus.hrdata     <= mem[bus.haddr];
  end

  always_ff @(posedge clk) begin
    if (rst) bus.hready <= 1'b0;
    else     bus.hready <= access;  // Pulse one cycle later
  end

endmodule

`default_nettype wire

//--- logic/dma_top.sv
////////////////////////////////////////
// DMA engine top
////////////////////////////////////////

`include "dma_defines.svh"

`default_nettype none

module dma_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cfg_hsel,
  input  logic                       cfg_hwrite,
  input  logic [`DMA_CFG_ADDR_W-1:0] cfg_haddr,
  input  dma_pkg::word_t             cfg_hwdata,
  output dma_pkg::word_t             cfg_hrdata,
  input  logic                       mem_req_valid,
  output logic                       mem_req_ready,
  input  logic                       mem_req_write,
  input  dma_pkg::maddr_t            mem_req_addr,
  input  dma_pkg::word_t             mem_req_wdata,
  output logic                       mem_rsp_valid,
  output dma_pkg::word_t             mem_rsp_rdata,
  input  logic                       mem_rsp_ready,
  output dma_pkg::slot_mask_t        irq
);

  dma_bus_if  acc_bus ();  // Access port to arbiter
  dma_bus_if  cpy_bus ();  // Copy engine to arbiter
  dma_bus_if  mem_bus ();  // Arbiter to SRAM
  dma_ctrl_if ctrl ();

  dma_request_table u_table (.clk, .rst, .cfg_hsel, .cfg_hwrite, .cfg_haddr,
                             .cfg_hwdata, .cfg_hrdata, .ctrl(ctrl.tbl), .irq);
  dma_copy_engine u_copy (.clk, .rst, .ctrl(ctrl.engine), .bus(cpy_bus.initiator));
  dma_access_port u_access (.clk, .rst, .mem_req_valid, .mem_req_ready, .mem_req_write,
                            .mem_req_addr, .mem_req_wdata, .mem_rsp_valid, .mem_rsp_rdata,
                            .mem_rsp_ready, .bus(acc_bus.initiator));
  dma_bus_arbiter u_arb (.clk, .rst, .acc(acc_bus.memory), .cpy(cpy_bus.memory),
                         .mem(mem_bus.initiator));
  dma_sram u_sram (.clk, .rst, .bus(mem_bus.memory));

endmodule

`default_nettype wire

//--- test/dma_top_chk.sv
////////////////////////////////////////
// DMA top assertions
////////////////////////////////////////

`default_nettype none

module dma_top_chk (
  input logic                clk,
  input logic                rst,
  input logic                mem_req_ready,
  input logic                mem_rsp_valid,
  input logic                mem_rsp_ready,
  input dma_pkg::word_t      mem_rsp_rdata,
  input dma_pkg::slot_mask_t irq,
  input dma_pkg::slot_mask_t valid,
  input logic                done_en,
  input dma_pkg::slot_t      done_pos,
  input logic                acc_hsel,
  input logic                cpy_hsel,
  input logic                acc_hready,
  input logic                cpy_hready,
  input logic                bus_busy,   // Any hsel or hmastlock
  input dma_pkg::bus_owner_e owner
);
  timeunit 1ns;
  timeprecision 100ps;
  import dma_pkg::*;

  int unsigned failures = 0;  // Count of failed properties
  slot_mask_t  done_mask;

  assign done_mask = slot_mask_t'(1) << done_pos;

  // Everything quiet one cycle after a reset edge
  reset_values: assert property (@(posedge clk)
    rst |=> (irq == '0 && valid == '0 && !mem_rsp_valid && !mem_req_ready &&
             !bus_busy && owner == OWN_ACCESS))
    else begin $error("reset values wrong"); failures++; end

  // Held response under back-pressure
  rsp_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_rsp_valid && !mem_rsp_ready) |=>
      (mem_rsp_valid && $stable(mem_rsp_rdata) && !mem_req_ready))
    else begin $error("response not held"); failures++; end

  done_to_irq: assert property (@(posedge clk) disable iff (rst)
    done_en |=> |(irq & $past(done_mask)))  // Done strobe sets its line
    else begin $error("done pulse lost"); failures++; end

  ////////////////////////////////////////
  // Grant rules
  ////////////////////////////////////////

  // Completion only for an access issued while granted
  acc_grant: assert property (@(posedge clk) disable iff (rst)
    acc_hready |-> acc_hsel && $past(owner == OWN_ACCESS && acc_hsel))
    else begin $error("hready to access port without grant"); failures++; end

  cpy_grant: assert property (@(posedge clk) disable iff (rst)
    cpy_hready |-> cpy_hsel && $past(owner == OWN_COPY && cpy_hsel))
    else begin $error("hready to copy engine without grant"); failures++; end

endmodule

bind dma_top dma_top_chk u_chk (
  .clk, .rst, .mem_req_ready, .mem_rsp_valid, .mem_rsp_ready, .mem_rsp_rdata, .irq,
  .valid(ctrl.valid), .done_en(ctrl.done_en), .done_pos(ctrl.done_pos),
  .acc_hsel(acc_bus.hsel), .cpy_hsel(cpy_bus.hsel),
  .acc_hready(acc_bus.hready), .cpy_hready(cpy_bus.hready),
  .bus_busy(acc_bus.hsel | acc_bus.hmastlock | cpy_bus.hsel | cpy_bus.hmastlock),
  .owner(u_arb.owner)
);

`default_nettype wire

//--- test/dma_top_tb.sv
////////////////////////////////////////
// DMA engine testbench
////////////////////////////////////////

`include "dma_defines.svh"

`default_nettype none

module dma_top_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import dma_pkg::*;

  localparam int SEED     = 91;
  localparam int TIMEOUT  = 20000;  // Cycles, whole run needs about 5000
  localparam int RUN_LEN  = 32;     // Words copied under access traffic
  localparam int RAND_OPS = 24;     // Access port requests during that copy

  logic       clk = 1'b0;
  logic       rst;
  logic       cfg_hsel;
  logic       cfg_hwrite;
  logic [`DMA_CFG_ADDR_W-1:0] cfg_haddr;
  word_t      cfg_hwdata;
  word_t      cfg_hrdata;
  logic       mem_req_valid;
  logic       mem_req_ready;
  logic       mem_req_write;
  maddr_t     mem_req_addr;
  word_t      mem_req_wdata;
  logic       mem_rsp_valid;
  word_t      mem_rsp_rdata;
  logic       mem_rsp_ready;
  slot_mask_t irq;

  word_t       model [`DMA_MEM_DEPTH];  // Reference memory
  maddr_t      d_src [`DMA_SLOTS];      // Descriptors as programmed
  maddr_t      d_dst [`DMA_SLOTS];
  len_t        d_len [`DMA_SLOTS];
  int unsigned cycles = 0;

  dma_top uut (.*);

  always #20 clk = ~clk;  // 40 ns period

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "Run stopped");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) abort_run("Timeout, DMA traffic did not finish in time");
  end

  always @(posedge clk) begin
    if (uut.u_chk.failures != 0) abort_run("A bound assertion on the DUT failed");
  end

  task automatic step();  // Next edge plus drive delay
    @(posedge clk);
    #1;
  endtask

  task automatic expect_eq(string name, word_t got, word_t exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run("Value check failed");
    end
  endtask

  ////////////////////////////////////////
  // Config and memory access
  ////////////////////////////////////////

  task automatic cfg_write(int s, logic [1:0] word, word_t data);
    cfg_hsel   = 1'b1;
    cfg_hwrite = 1'b1;
    cfg_haddr  = {slot_t'(s), word, 2'b00};
    cfg_hwdata = data;
    step();
    cfg_hsel   = 1'b0;
  endtask

  task automatic cfg_read(int s, logic [1:0] word, output word_t data);
    cfg_hsel   = 1'b1;
    cfg_hwrite = 1'b0;
    cfg_haddr  = {slot_t'(s), word, 2'b00};
    step();
    cfg_hsel   = 1'b0;
    data       = cfg_hrdata;  // Registered at that edge
  endtask

  task automatic mem_access(logic wr, maddr_t addr, word_t wdata, bit stall,
                            output word_t rdata);
    logic taken;
    taken = 1'b0;
    while (!mem_req_ready) step();
    mem_req_valid = 1'b1;
    mem_req_write = wr;
    mem_req_addr  = addr;
    mem_req_wdata = wdata;
    step();
    mem_req_valid = 1'b0;
    while (!taken) begin
      mem_rsp_ready = stall ? (($urandom % 4) != 0) : 1'b1;  // Random back-pressure
      taken         = mem_rsp_valid && mem_rsp_ready;
      rdata         = mem_rsp_rdata;
      step();
    end
    mem_rsp_ready = 1'b0;
  endtask

  task automatic mem_write(maddr_t addr, word_t data, bit stall);
    word_t r;
    mem_access(1'b1, addr, data, stall, r);
    expect_eq("mem_rsp_rdata on write", r, '0);
    model[addr] = data;
  endtask

  task automatic check_region(maddr_t base, int n, bit stall);
    word_t r;
    for (int i = 0; i < n; i++) begin
      mem_access(1'b0, maddr_t'(base + i), '0, stall, r);
      expect_eq($sformatf("mem_rsp_rdata @%02h", maddr_t'(base + i)), r,
                model[maddr_t'(base + i)]);
    end
  endtask

  ////////////////////////////////////////
  // Slot handling
  ////////////////////////////////////////

  task automatic set_slot(int s, maddr_t src, maddr_t dst, len_t len);
    d_src[s] = src;
    d_dst[s] = dst;
    d_len[s] = len;
    cfg_write(s, 2'd0, word_t'(src));
    cfg_write(s, 2'd1, word_t'(dst));
    cfg_write(s, 2'd2, word_t'(len));
  endtask

  // Word by word in rising order, so overlap behaves like the engine
  task automatic apply_copy(int s);
    for (int i = 0; i < d_len[s]; i++) begin
      model[maddr_t'(d_dst[s] + i)] = model[maddr_t'(d_src[s] + i)];
    end
  endtask

  task automatic wait_done(int s);
    while (!irq[s]) step();
    apply_copy(s);
  endtask

  task automatic clear_done(int s);
    word_t r;
    cfg_write(s, 2'd3, 32'h2);
    cfg_read(s, 2'd3, r);
    expect_eq($sformatf("ctrl of slot %0d", s), r, '0);  // Valid 0, done 0
    expect_eq($sformatf("irq[%0d]", s), word_t'(irq[s]), '0);
  endtask

  initial begin
    word_t      r;
    slot_mask_t seen;
    maddr_t     a;
    rst           = 1'b1;
    cfg_hsel      = 1'b0;
    cfg_hwrite    = 1'b0;
    cfg_haddr     = '0;
    cfg_hwdata    = '0;
    mem_req_valid = 1'b0;
    mem_req_write = 1'b0;
    mem_req_addr  = '0;
    mem_req_wdata = '0;
    mem_rsp_ready = 1'b0;
    void'($urandom(SEED));
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Quiet state out of reset
    expect_eq("irq", word_t'(irq), '0);
    expect_eq("mem_rsp_valid", word_t'(mem_rsp_valid), '0);
    for (int s = 0; s < `DMA_SLOTS; s++) begin
      cfg_read(s, 2'd3, r);
      expect_eq($sformatf("ctrl of slot %0d", s), r, '0);
    end

    // Descriptor write then read back
    set_slot(3, 8'h5A, 8'hA5, 8'h07);
    cfg_read(3, 2'd0, r);
    expect_eq("src of slot 3", r, 32'h5A);
    cfg_read(3, 2'd1, r);
    expect_eq("dst of slot 3", r, 32'hA5);
    cfg_read(3, 2'd2, r);
    expect_eq("len of slot 3", r, 32'h07);

    for (int i = 0; i < `DMA_MEM_DEPTH; i++) mem_write(maddr_t'(i), $urandom, 1'b0);

    // Single copy, src locked while pending
    set_slot(0, 8'h10, 8'h40, 8'd8);
    cfg_write(0, 2'd3, 32'h1);
    cfg_write(0, 2'd0, 32'h33);
    cfg_read(0, 2'd0, r);
    expect_eq("src of pending slot 0", r, 32'h10);
    wait_done(0);
    check_region(8'h3E, 12, 1'b0);  // Region plus neighbours
    clear_done(0);

    // Four slots queued together, slot 2 empty
    set_slot(0, 8'h00, 8'h20, 8'd6);
    set_slot(1, 8'h20, 8'h28, 8'd4);
    set_slot(2, 8'h30, 8'h50, 8'd0);
    set_slot(3, 8'h60, 8'h62, 8'd5);
    for (int s = 0; s < `DMA_SLOTS; s++) cfg_write(s, 2'd3, 32'h1);
    seen = '0;
    while (seen != '1) begin
      if (irq != seen) begin
        expect_eq("irq order", word_t'(irq), word_t'(slot_mask_t'((seen << 1) | 1'b1)));
        for (int s = 0; s < `DMA_SLOTS; s++) if (irq[s] && !seen[s]) apply_copy(s);
        seen = irq;
      end
      step();
    end
    check_region(8'h00, `DMA_MEM_DEPTH, 1'b0);
    for (int s = 0; s < `DMA_SLOTS; s++) clear_done(s);

    // Stalled access port traffic while a long copy runs
    set_slot(1, 8'h80, 8'hC0, len_t'(RUN_LEN));
    cfg_write(1, 2'd3, 32'h1);
    for (int k = 0; k < RAND_OPS; k++) begin
      a = maddr_t'($urandom % 64);  // Clear of the copy regions
      if ($urandom % 2) mem_write(a, $urandom, 1'b1);
      else check_region(a, 1, 1'b1);
    end
    wait_done(1);
    check_region(8'hBE, RUN_LEN + 4, 1'b1);
    clear_done(1);

    step();
    if (uut.u_chk.failures == 0) begin
      $display("No errors");
      $finish;
    end else begin
      abort_run("Bound assertions on the DUT failed");
    end
  end

endmodule

`default_nettype wire

//--- dma_engine.f
+incdir+logic
logic/dma_pkg.sv
logic/dma_ifs.sv
logic/dma_request_table.sv
logic/dma_copy_engine.sv
logic/dma_access_port.sv
logic/dma_bus_arbiter.sv
logic/dma_sram.sv
logic/dma_top.sv
test/dma_top_chk.sv
test/dma_top_tb.sv

//--- Makefile
# Verilator build for the DMA engine testbench

VERILATOR ?= verilator
TOP       ?= dma_top_tb
FILELIST  ?= dma_engine.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=

SOURCES := $(wildcard logic/*.sv logic/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
